// File: include/lsu_iq_settings.svh
`ifndef LSU_IQ_SETTINGS_SVH
`define LSU_IQ_SETTINGS_SVH

// queue geometry
`define LSU_IQ_DEPTH 8
`define LSU_IQ_IDX_W 4  // tail counts 0..depth

// physical register number
`define PREG_W 6

// writeback ports snooped by every slot
`define WAKE_PORTS 4

// micro-op fields
`define OFFSET_W 12
`define LSU_TAG_W 8

`endif

// File: src/lsu_iq_pkg.sv
`default_nettype none

`include "lsu_iq_settings.svh"

package lsu_iq_pkg;

    typedef struct packed {
        logic [`PREG_W-1:0]   dst_preg;
        logic                 dst_we;
        logic [`PREG_W-1:0]   base_preg;  // source 1
        logic [`OFFSET_W-1:0] offset;
    } lsu_load_ops_t;

    // data_preg lines up with dst_preg of the load view
    typedef struct packed {
        logic [`PREG_W-1:0]   data_preg;  // source 2
        logic                 spare;
        logic [`PREG_W-1:0]   base_preg;  // source 1
        logic [`OFFSET_W-1:0] offset;
    } lsu_store_ops_t;

    // is_store picks which view of this word applies
    typedef union packed {
        lsu_load_ops_t  load;
        lsu_store_ops_t store;
    } lsu_operands_t;

    typedef struct packed {
        logic                  is_store;
        logic                  src1_rdy;
        logic                  src2_rdy;   // loads arrive with this set
        logic [`LSU_TAG_W-1:0] tag;        // rob index passed through
        lsu_operands_t         operands;
    } lsu_iq_rec_t;

endpackage

`default_nettype wire

// File: src/lsu_iq_entry.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_iq_settings.svh"

module lsu_iq_entry (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_en,
    input  logic                                enq_sel,   // 1 picks dispatch slot 1
    input  logic                                shift_en,
    input  logic [`WAKE_PORTS-1:0]              wake_en,
    input  logic [`WAKE_PORTS-1:0][`PREG_W-1:0] wake_preg,
    input  lsu_iq_pkg::lsu_iq_rec_t             enq_rec_0,
    input  lsu_iq_pkg::lsu_iq_rec_t             enq_rec_1,
    input  lsu_iq_pkg::lsu_iq_rec_t             up_rec,
    output lsu_iq_pkg::lsu_iq_rec_t             rec,
    output logic                                rdy
);
    import lsu_iq_pkg::*;

    lsu_iq_rec_t next_rec;
    lsu_iq_rec_t wake_rec;
    logic        src1_hit;
    logic        src2_hit;

    assign next_rec = enq_en   ? (enq_sel ? enq_rec_1 : enq_rec_0) :
                      shift_en ? up_rec : rec;

    // snoop the content the slot is about to hold, so moving entries keep wakes
    always_comb begin
        src1_hit = 1'b0;
        src2_hit = 1'b0;
        for (int p = 0; p < `WAKE_PORTS; p++) begin
            if (wake_en[p] && wake_preg[p] == next_rec.operands.store.base_preg)
                src1_hit = 1'b1;
            if (wake_en[p] && wake_preg[p] == next_rec.operands.store.data_preg)
                src2_hit = next_rec.is_store;  // loads have no source 2
        end
        wake_rec          = next_rec;
        wake_rec.src1_rdy = next_rec.src1_rdy | src1_hit;
        wake_rec.src2_rdy = next_rec.src2_rdy | src2_hit;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rec.is_store <= 1'b0;
            rec.src1_rdy <= 1'b0;
            rec.src2_rdy <= 1'b1;  // idle slot reads as a load
        end else begin
            rec <= wake_rec;
        end
    end

    assign rdy = rec.src1_rdy & rec.src2_rdy;

    a_enq_shift_excl: assert property (@(posedge clk) disable iff (rst)
        !(enq_en && shift_en))
        else $error("slot told to enqueue and shift at once");

    // dispatch marks source 2 ready on loads and nothing clears it
    a_load_src2: assert property (@(posedge clk) disable iff (rst)
        !rec.is_store |-> rec.src2_rdy)
        else $error("load held with source 2 not ready");

endmodule

`default_nettype wire

// File: src/lsu_iq_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_iq_settings.svh"

module lsu_iq_queue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_req_0,
    input  logic                                enq_req_1,
    input  lsu_iq_pkg::lsu_iq_rec_t             enq_rec_0,
    input  lsu_iq_pkg::lsu_iq_rec_t             enq_rec_1,
    input  logic                                deq_req,
    input  logic [`LSU_IQ_IDX_W-2:0]            deq_idx,
    input  logic [`WAKE_PORTS-1:0]              wake_en,
    input  logic [`WAKE_PORTS-1:0][`PREG_W-1:0] wake_preg,
    output lsu_iq_pkg::lsu_iq_rec_t             deq_rec,
    output logic [`LSU_IQ_DEPTH-1:0]            valid_vec,
    output logic [`LSU_IQ_DEPTH-1:0]            ready_vec,
    output logic [`LSU_IQ_DEPTH-1:0]            store_vec,
    output logic                                occupancy_high
);
    import lsu_iq_pkg::*;

    logic [`LSU_IQ_IDX_W-1:0] tail;     // number of valid entries
    logic                     enq_0;
    logic                     enq_1;
    logic [`LSU_IQ_IDX_W-1:0] pos_0;
    logic [`LSU_IQ_IDX_W-1:0] pos_1;
    logic [`LSU_IQ_DEPTH-1:0] enq_en;
    logic [`LSU_IQ_DEPTH-1:0] enq_sel;
    logic [`LSU_IQ_DEPTH-1:0] shift_en;
    lsu_iq_rec_t              slot_rec [`LSU_IQ_DEPTH:0];

    // 7 or 8 entries leave no room for a pair
    assign occupancy_high = (tail >= `LSU_IQ_DEPTH - 1);

    assign enq_0 = enq_req_0 && !occupancy_high;
    assign enq_1 = enq_req_1 && !occupancy_high;

    // write positions after this cycle's compaction
    assign pos_0 = tail - deq_req;
    assign pos_1 = pos_0 + enq_0;  // slot 1 lands on pos_0 when alone

    assign slot_rec[`LSU_IQ_DEPTH] = '0;  // nothing above the top slot

    for (genvar i = 0; i < `LSU_IQ_DEPTH; i++) begin : g_slot
        assign enq_en[i]    = (enq_0 && pos_0 == i) || (enq_1 && pos_1 == i);
        assign enq_sel[i]   = enq_1 && pos_1 == i;
        // only slots whose upper neighbour is valid close the gap
        assign shift_en[i]  = deq_req && i >= deq_idx && i + 1 < tail;
        assign valid_vec[i] = i < tail;
        assign store_vec[i] = slot_rec[i].is_store;

        lsu_iq_entry i_lsu_iq_entry (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .enq_en    (enq_en[i]),
            .enq_sel   (enq_sel[i]),
            .shift_en  (shift_en[i]),
            .wake_en   (wake_en),
            .wake_preg (wake_preg),
            .enq_rec_0 (enq_rec_0),
            .enq_rec_1 (enq_rec_1),
            .up_rec    (slot_rec[i+1]),
            .rec       (slot_rec[i]),
            .rdy       (ready_vec[i])
        );
    end

    assign deq_rec = slot_rec[deq_idx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= tail + enq_0 + enq_1 - deq_req;
        end
    end

    a_tail_bound: assert property (@(posedge clk) disable iff (rst)
        tail <= `LSU_IQ_DEPTH)
        else $error("tail beyond queue depth");

    a_enq_when_full: assert property (@(posedge clk) disable iff (rst)
        (enq_req_0 || enq_req_1) |-> !occupancy_high)
        else $error("enqueue request dropped, queue not ready");

    a_deq_in_range: assert property (@(posedge clk) disable iff (rst)
        deq_req |-> deq_idx < tail)
        else $error("dequeue index %0d not below tail %0d", deq_idx, tail);

endmodule

`default_nettype wire

// File: src/store_order_mask.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_iq_settings.svh"

module store_order_mask (
    input  logic [`LSU_IQ_DEPTH-1:0] store_vec,
    output logic [`LSU_IQ_DEPTH-1:0] order_mask
);

    // open up to and including the oldest store or everything when none
    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `LSU_IQ_DEPTH; i++) begin
            order_mask[i] = !seen;
            if (store_vec[i])
                seen = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/issue_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_iq_settings.svh"

module issue_select (
    input  logic [`LSU_IQ_DEPTH-1:0] elig_vec,
    output logic [`LSU_IQ_IDX_W-2:0] sel_idx,
    output logic                     sel_valid
);

    // index 0 is the oldest, so the lowest set bit wins
    always_comb begin
        sel_idx   = '0;
        sel_valid = 1'b0;
        for (int i = `LSU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (elig_vec[i]) begin
                sel_idx   = i[`LSU_IQ_IDX_W-2:0];
                sel_valid = 1'b1;
            end
        end
    end

    always_comb begin
        a_sel_elig: assert final (!sel_valid || elig_vec[sel_idx])
            else $error("selected entry %0d is not eligible", sel_idx);
    end

endmodule

`default_nettype wire

// File: src/lsu_issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_iq_settings.svh"

module lsu_issue_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_req_0,
    input  logic                                enq_req_1,
    input  lsu_iq_pkg::lsu_iq_rec_t             enq_rec_0,
    input  lsu_iq_pkg::lsu_iq_rec_t             enq_rec_1,
    input  logic [`WAKE_PORTS-1:0]              wake_en,
    input  logic [`WAKE_PORTS-1:0][`PREG_W-1:0] wake_preg,
    input  logic                                lsu_busy,
    output logic                                ready,
    output logic                                issue_en,
    output logic [`LSU_TAG_W-1:0]               issue_tag,
    output logic                                issue_is_store,
    output lsu_iq_pkg::lsu_operands_t           issue_operands
);
    import lsu_iq_pkg::*;

    logic [`LSU_IQ_DEPTH-1:0] valid_vec;
    logic [`LSU_IQ_DEPTH-1:0] ready_vec;
    logic [`LSU_IQ_DEPTH-1:0] store_vec;
    logic [`LSU_IQ_DEPTH-1:0] order_mask;
    logic [`LSU_IQ_DEPTH-1:0] elig_vec;
    logic [`LSU_IQ_IDX_W-2:0] sel_idx;
    logic                     sel_valid;
    logic                     occupancy_high;
    lsu_iq_rec_t              deq_rec;

    lsu_iq_queue i_lsu_iq_queue (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .enq_req_0      (enq_req_0),
        .enq_req_1      (enq_req_1),
        .enq_rec_0      (enq_rec_0),
        .enq_rec_1      (enq_rec_1),
        .deq_req        (sel_valid),  // whatever is selected leaves this edge
        .deq_idx        (sel_idx),
        .wake_en        (wake_en),
        .wake_preg      (wake_preg),
        .deq_rec        (deq_rec),
        .valid_vec      (valid_vec),
        .ready_vec      (ready_vec),
        .store_vec      (store_vec),
        .occupancy_high (occupancy_high)
    );

    store_order_mask i_store_order_mask (
        .store_vec  (store_vec),
        .order_mask (order_mask)
    );

    // busy blocks every entry
    assign elig_vec = ready_vec & valid_vec & order_mask & {`LSU_IQ_DEPTH{~lsu_busy}};

    issue_select i_issue_select (
        .elig_vec  (elig_vec),
        .sel_idx   (sel_idx),
        .sel_valid (sel_valid)
    );

    assign ready          = ~occupancy_high;
    assign issue_en       = sel_valid;
    assign issue_tag      = deq_rec.tag;
    assign issue_is_store = deq_rec.is_store;
    assign issue_operands = deq_rec.operands;

endmodule

`default_nettype wire

// File: tests/lsu_issue_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_iq_settings.svh"

module lsu_issue_unit_tb;
    import lsu_iq_pkg::*;

    localparam int DEPTH       = `LSU_IQ_DEPTH;
    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 16 + 150 + 300 + 60;  // reset, directed, random, final

    logic                                clk = 1'b0;
    logic                                rst = 1'b1;
    logic                                flush = 1'b0;
    logic                                enq_req_0 = 1'b0;
    logic                                enq_req_1 = 1'b0;
    lsu_iq_rec_t                         enq_rec_0 = '0;
    lsu_iq_rec_t                         enq_rec_1 = '0;
    logic [`WAKE_PORTS-1:0]              wake_en = '0;
    logic [`WAKE_PORTS-1:0][`PREG_W-1:0] wake_preg = '0;
    logic                                lsu_busy = 1'b0;
    logic                                ready;
    logic                                issue_en;
    logic [`LSU_TAG_W-1:0]               issue_tag;
    logic                                issue_is_store;
    lsu_operands_t                       issue_operands;

    // reference queue with the oldest at index 0
    lsu_iq_rec_t m_q [DEPTH];
    int          m_cnt = 0;
    logic        exp_en;
    int          exp_idx;
    lsu_iq_rec_t exp_rec;
    logic        exp_ready;
    int          next_cnt;     // model count after the coming edge

    string test_name = "reset";
    int    err_cnt = 0;
    int    err_start = 0;
    int    tests_pass = 0;
    int    tests_fail = 0;
    int    seed;

    lsu_issue_unit i_lsu_issue_unit (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .enq_req_0      (enq_req_0),
        .enq_req_1      (enq_req_1),
        .enq_rec_0      (enq_rec_0),
        .enq_rec_1      (enq_rec_1),
        .wake_en        (wake_en),
        .wake_preg      (wake_preg),
        .lsu_busy       (lsu_busy),
        .ready          (ready),
        .issue_en       (issue_en),
        .issue_tag      (issue_tag),
        .issue_is_store (issue_is_store),
        .issue_operands (issue_operands)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // oldest ready entry not past the oldest store
    always_comb begin
        logic store_seen;
        store_seen = 1'b0;
        exp_en     = 1'b0;
        exp_idx    = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (i < m_cnt && !exp_en && !store_seen && !lsu_busy &&
                m_q[i].src1_rdy && m_q[i].src2_rdy) begin
                exp_en  = 1'b1;
                exp_idx = i;
            end
            if (i < m_cnt && m_q[i].is_store)
                store_seen = 1'b1;
        end
        exp_rec   = m_q[exp_idx];
        exp_ready = m_cnt < DEPTH - 1;
        next_cnt  = m_cnt - int'(exp_en) + int'(exp_ready && enq_req_0) +
                    int'(exp_ready && enq_req_1);
    end

    function automatic lsu_iq_rec_t apply_wakes(input lsu_iq_rec_t r);
        lsu_iq_rec_t w;
        w = r;
        for (int p = 0; p < `WAKE_PORTS; p++) begin
            if (wake_en[p] && wake_preg[p] == r.operands.load.base_preg)
                w.src1_rdy = 1'b1;
            if (wake_en[p] && r.is_store && wake_preg[p] == r.operands.store.data_preg)
                w.src2_rdy = 1'b1;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        lsu_iq_rec_t q [DEPTH];
        int          n;
        if (rst || flush) begin
            m_cnt <= 0;
        end else begin
            n = 0;
            for (int i = 0; i < m_cnt; i++) begin
                if (!(exp_en && i == exp_idx)) begin
                    q[n] = m_q[i];
                    n++;
                end
            end
            if (exp_ready && enq_req_0) begin
                q[n] = enq_rec_0;
                n++;
            end
            if (exp_ready && enq_req_1) begin
                q[n] = enq_rec_1;
                n++;
            end
            for (int i = 0; i < n; i++)
                m_q[i] <= apply_wakes(q[i]);  // a wake at the enqueue edge counts
            m_cnt <= n;
        end
    end

    task automatic report_value(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("ERROR %s %s expected %0h actual %0h", test_name, what, exp, act);
        err_cnt++;
    endtask

    a_issue_en: assert property (@(posedge clk) disable iff (rst) issue_en == exp_en)
        else report_value("issue_en", $sampled(exp_en), $sampled(issue_en));

    a_issue_rec: assert property (@(posedge clk) disable iff (rst)
        (issue_en && exp_en) |->
        {issue_is_store, issue_tag, issue_operands} ==
        {exp_rec.is_store, exp_rec.tag, exp_rec.operands})
        else report_value("issued record",
            $sampled({exp_rec.is_store, exp_rec.tag, exp_rec.operands}),
            $sampled({issue_is_store, issue_tag, issue_operands}));

    a_ready: assert property (@(posedge clk) disable iff (rst) ready == exp_ready)
        else report_value("ready", $sampled(exp_ready), $sampled(ready));

    function automatic lsu_iq_rec_t make_load(input logic [7:0] tag, input logic [5:0] base,
                                              input logic base_rdy);
        lsu_iq_rec_t r;
        r = '0;
        r.tag                     = tag;
        r.src1_rdy                = base_rdy;
        r.src2_rdy                = 1'b1;
        r.operands.load.dst_preg  = tag[5:0];
        r.operands.load.dst_we    = 1'b1;
        r.operands.load.base_preg = base;
        r.operands.load.offset    = {tag[3:0], tag};
        return r;
    endfunction

    function automatic lsu_iq_rec_t make_store(input logic [7:0] tag, input logic [5:0] base,
                                               input logic [5:0] data, input logic data_rdy);
        lsu_iq_rec_t r;
        r = make_load(tag, base, 1'b1);
        r.is_store                 = 1'b1;
        r.src2_rdy                 = data_rdy;
        r.operands.store.data_preg = data;
        r.operands.store.spare     = 1'b0;
        return r;
    endfunction

    function automatic lsu_iq_rec_t random_rec();
        logic [7:0] tag;
        tag = 8'($random(seed));
        if ($random(seed) & 3)
            return make_load(tag, 6'($random(seed) & 15), 1'($random(seed)));
        return make_store(tag, 6'($random(seed) & 15), 6'($random(seed) & 15),
                          1'($random(seed)));
    endfunction

    // inputs fall back to idle unless set again at this edge
    task automatic next_cycle();
        @(posedge clk);
        enq_req_0 <= 1'b0;
        enq_req_1 <= 1'b0;
        wake_en   <= '0;
        flush     <= 1'b0;
    endtask

    task automatic push(input lsu_iq_rec_t r, input int slot);
        if (slot == 0) begin
            enq_req_0 <= 1'b1;
            enq_rec_0 <= r;
        end else begin
            enq_req_1 <= 1'b1;
            enq_rec_1 <= r;
        end
    endtask

    task automatic wake(input int port, input logic [5:0] preg);
        wake_en[port]   <= 1'b1;
        wake_preg[port] <= preg;
    endtask

    task automatic wait_issue(input logic [7:0] tag, input int max_cycles);
        for (int c = 0; c < max_cycles; c++) begin
            next_cycle();
            if (issue_en && issue_tag == tag)
                return;
        end
        $display("test %s: tag %0h was not issued within %0d cycles", test_name, tag,
                 max_cycles);
        err_cnt++;
    endtask

    task automatic wait_empty(input int max_cycles);
        for (int c = 0; c < max_cycles; c++) begin
            next_cycle();
            if (m_cnt == 0)
                return;
        end
        $display("test %s: queue did not drain within %0d cycles", test_name, max_cycles);
        err_cnt++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_start = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == err_start) begin
            tests_pass++;
            $display("test %s finished, no errors", test_name);
        end else begin
            tests_fail++;
            $display("test %s finished, %0d errors", test_name, err_cnt - err_start);
        end
    endtask

    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog: simulation hung, tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed = 52;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset_state");
        next_cycle();
        next_cycle();
        push(make_load(8'h11, 6'd3, 1'b1), 0);
        wait_issue(8'h11, 4);
        end_test();

        begin_test("wakeup");
        next_cycle();
        push(make_load(8'h21, 6'd5, 1'b0), 0);
        repeat (3) next_cycle();  // held while the base is not ready
        wake(2, 6'd5);
        wait_issue(8'h21, 4);
        next_cycle();
        push(make_load(8'h22, 6'd9, 1'b0), 1);
        wake(0, 6'd9);            // same edge as the enqueue
        wait_issue(8'h22, 4);
        end_test();

        begin_test("age_order");
        next_cycle();
        lsu_busy <= 1'b1;
        push(make_load(8'h31, 6'd12, 1'b0), 0);
        push(make_load(8'h32, 6'd1, 1'b1), 1);
        next_cycle();
        push(make_load(8'h33, 6'd1, 1'b1), 0);
        push(make_load(8'h34, 6'd1, 1'b1), 1);
        next_cycle();
        lsu_busy <= 1'b0;
        repeat (4) next_cycle();
        wake(1, 6'd12);
        wait_empty(10);
        end_test();

        begin_test("store_order");
        next_cycle();
        lsu_busy <= 1'b1;
        push(make_load(8'h41, 6'd2, 1'b1), 0);
        push(make_store(8'h42, 6'd2, 6'd20, 1'b0), 1);
        next_cycle();
        push(make_load(8'h43, 6'd2, 1'b1), 0);
        push(make_load(8'h44, 6'd2, 1'b1), 1);
        next_cycle();
        lsu_busy <= 1'b0;
        repeat (5) next_cycle();  // younger loads wait behind the store
        wake(3, 6'd20);
        wait_empty(10);
        end_test();

        begin_test("busy_full");
        next_cycle();
        lsu_busy <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            if (next_cnt < DEPTH - 1)
                push(make_load(8'(8'h50 + i), 6'd1, 1'b1), 0);
        end
        repeat (3) next_cycle();
        lsu_busy <= 1'b0;
        wait_empty(15);
        end_test();

        begin_test("flush_random");
        for (int c = 0; c < 300; c++) begin
            next_cycle();
            lsu_busy <= ($random(seed) & 3) == 0;
            if (($random(seed) & 31) == 0)
                flush <= 1'b1;
            for (int p = 0; p < `WAKE_PORTS; p++) begin
                if ($random(seed) & 1)
                    wake(p, 6'($random(seed) & 15));
            end
            if (next_cnt < DEPTH - 1) begin
                if ($random(seed) & 1)
                    push(random_rec(), 0);
                if ($random(seed) & 1)
                    push(random_rec(), 1);
            end
        end
        next_cycle();
        lsu_busy <= 1'b0;
        flush    <= 1'b1;
        repeat (6) next_cycle();  // nothing issues from the empty queue
        push(make_load(8'h6a, 6'd4, 1'b1), 0);
        wait_issue(8'h6a, 4);
        end_test();

        repeat (2) next_cycle();
        $display("tests passed %0d failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
        if (tests_fail == 0 && err_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
src/lsu_iq_pkg.sv
src/lsu_iq_entry.sv
src/lsu_iq_queue.sv
src/store_order_mask.sv
src/issue_select.sv
src/lsu_issue_unit.sv
tests/lsu_issue_unit_tb.sv
